// File: Makefile
TOOL     = verilator
FLAGS    = --binary --assert
TOP      = f2_system_ctrl_tb
FILELIST = f2_system_ctrl.f

.PHONY: all lint clean

all:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Simulation passed"

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// File: f2_system_ctrl.f
+incdir+testbench
source/f2_bus_pkg.sv
source/f2_irq_pkg.sv
source/f2_chip_select.sv
source/f2_region_config.sv
source/f2_work_ram.sv
source/f2_irq_ctrl.sv
source/f2_cpu_bus.sv
source/f2_system_ctrl.sv
testbench/f2_system_ctrl_tb.sv

// File: source/f2_bus_pkg.sv
package f2_bus_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Main CPU bus geometry

    // Word address, CPU address bits 23 to 1
    localparam int ADDR_W = 23;
    localparam int DATA_W = 16;
    localparam int SEL_W = 2;
    localparam int PAGE_W = 8;

    // First word-address bit of the page number
    localparam int PAGE_LSB = ADDR_W - PAGE_W;

    typedef logic [ADDR_W-1:0] bus_addr_t;
    typedef logic [DATA_W-1:0] bus_data_t;

    // Bit 1 is the upper byte lane
    typedef logic [SEL_W-1:0] bus_sel_t;

    // Page number, CPU address bits 23 to 16
    typedef logic [PAGE_W-1:0] page_t;

    ////////////////////////////////////////////////////////////////////////////
    // Address map

    // Configuration block never moves
    localparam page_t CONFIG_PAGE = 8'h70;

    typedef enum logic [1:0] {
        REGION_NONE,
        REGION_WORK_RAM,
        REGION_IRQ,
        REGION_CONFIG
    } region_t;

    // Word offsets inside the configuration page
    localparam bus_addr_t CFG_WORK_RAM_OFFSET = 23'd0;
    localparam bus_addr_t CFG_IRQ_OFFSET = 23'd1;

endpackage

// File: source/f2_chip_select.sv
`timescale 1ns/1ps

module f2_chip_select (
    input  f2_bus_pkg::bus_addr_t addr,
    input  f2_bus_pkg::page_t     work_ram_page,
    input  f2_bus_pkg::page_t     irq_page,
    output f2_bus_pkg::region_t   region
);

    import f2_bus_pkg::*;

    page_t addr_page;

    assign addr_page = addr[ADDR_W-1:PAGE_LSB];

    ////////////////////////////////////////////////////////////////////////////
    // Page decode
    //
    // Fixed config page is checked before the remappable bases, and work RAM
    // wins over IRQ when both bases point at the same page. That keeps the
    // config block reachable whatever the CPU has written into the bases.

    always_comb begin
        if (addr_page == CONFIG_PAGE) begin
            region = REGION_CONFIG;
        end else if (addr_page == work_ram_page) begin
            region = REGION_WORK_RAM;
        end else if (addr_page == irq_page) begin
            region = REGION_IRQ;
        end else begin
            // Unmapped, still acked by the bus
            region = REGION_NONE;
        end
    end

endmodule

// File: source/f2_cpu_bus.sv
`timescale 1ns/1ps

module f2_cpu_bus (
    input  logic                  clk,
    input  logic                  reset,

    // Wishbone classic slave
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  f2_bus_pkg::bus_addr_t wb_adr,
    input  f2_bus_pkg::bus_data_t wb_dat_w,
    input  f2_bus_pkg::bus_sel_t  wb_sel,
    output f2_bus_pkg::bus_data_t wb_dat_r,
    output logic                  wb_ack,

    input  f2_bus_pkg::region_t   region,

    // Shared target side
    output f2_bus_pkg::bus_addr_t offset,
    output f2_bus_pkg::bus_data_t wr_data,
    output f2_bus_pkg::bus_sel_t  wr_sel,
    output logic                  wr_en,

    output logic                  ram_stb,
    output logic                  irq_stb,
    output logic                  cfg_stb,
    input  f2_bus_pkg::bus_data_t ram_data,
    input  f2_bus_pkg::bus_data_t irq_data,
    input  f2_bus_pkg::bus_data_t cfg_data
);

    import f2_bus_pkg::*;

    logic new_req;
    region_t region_q;

    // Ack cycle masked since the master still holds the request
    assign new_req = wb_cyc & wb_stb & ~wb_ack;

    assign ram_stb = new_req & (region == REGION_WORK_RAM);
    assign irq_stb = new_req & (region == REGION_IRQ);
    assign cfg_stb = new_req & (region == REGION_CONFIG);

    assign offset = bus_addr_t'(wb_adr[PAGE_LSB-1:0]);
    assign wr_data = wb_dat_w;
    assign wr_sel = wb_sel;
    assign wr_en = wb_we;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= new_req;
        end
    end

    always_ff @(posedge clk) begin
        if (new_req) begin
            region_q <= region;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read data mux for the ack cycle

    always_comb begin
        wb_dat_r = '0;
        if (wb_ack) begin
            case (region_q)
                REGION_WORK_RAM: wb_dat_r = ram_data;
                REGION_IRQ:      wb_dat_r = irq_data;
                REGION_CONFIG:   wb_dat_r = cfg_data;
                default:         wb_dat_r = '0;
            endcase
        end
    end

    // Master keeps the request steady until it sees ack
    req_held: assert property (@(posedge clk) disable iff (reset)
        (wb_cyc && wb_stb && !wb_ack) |=>
            (wb_cyc && wb_stb && $stable(wb_adr) && $stable(wb_we)));

endmodule

// File: source/f2_irq_ctrl.sv
`timescale 1ns/1ps

module f2_irq_ctrl (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   vblank,
    input  logic                   dma_done,
    input  logic                   stb,
    input  logic                   we,
    input  f2_bus_pkg::bus_addr_t  offset,
    output f2_bus_pkg::bus_data_t  rd_data,
    output f2_irq_pkg::irq_level_t ipl
);

    import f2_bus_pkg::*;
    import f2_irq_pkg::*;

    logic vblank_prev;
    logic dma_prev;
    logic vblank_req;
    logic dma_req;
    logic vblank_rise;
    logic dma_rise;
    logic clear_vblank;
    logic clear_dma;

    assign vblank_rise = vblank & ~vblank_prev;
    assign dma_rise = dma_done & ~dma_prev;

    assign clear_vblank = stb & we & (offset == bus_addr_t'(IRQ_CLEAR_VBLANK_OFFSET));
    assign clear_dma = stb & we & (offset == bus_addr_t'(IRQ_CLEAR_DMA_OFFSET));

    // Previous input levels for edge capture
    always_ff @(posedge clk) begin
        vblank_prev <= vblank;
        dma_prev <= dma_done;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pending requests

    always_ff @(posedge clk) begin
        if (reset) begin
            vblank_req <= 1'b0;
            dma_req <= 1'b0;
        end else begin
            // Edge in the clear cycle keeps the request
            vblank_req <= vblank_rise | (vblank_req & ~clear_vblank);
            dma_req <= dma_rise | (dma_req & ~clear_dma);
        end
    end

    always_comb begin
        if (dma_req) begin
            ipl = IRQ_DMA;
        end else if (vblank_req) begin
            ipl = IRQ_VBLANK;
        end else begin
            ipl = IRQ_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (stb) begin
            rd_data <= '0;
            if (offset == bus_addr_t'(IRQ_STATUS_OFFSET)) begin
                rd_data[IRQ_STATUS_VBLANK_BIT] <= vblank_req;
                rd_data[IRQ_STATUS_DMA_BIT] <= dma_req;
            end
        end
    end

    // DMA edge raises the top level on the next cycle even during a clear
    dma_edge_level: assert property (@(posedge clk) disable iff (reset)
        $rose(dma_done) |=> (ipl == IRQ_DMA));

endmodule

// File: source/f2_irq_pkg.sv
package f2_irq_pkg;

    // Level presented to the CPU, DMA above vblank
    typedef enum logic [2:0] {
        IRQ_NONE = 3'd0,
        IRQ_VBLANK = 3'd5,
        IRQ_DMA = 3'd6
    } irq_level_t;

    ////////////////////////////////////////////////////////////////////////////
    // Register word offsets inside the IRQ page

    // Pending bits, read only
    localparam int unsigned IRQ_STATUS_OFFSET = 0;

    // Write anything to drop the request
    localparam int unsigned IRQ_CLEAR_VBLANK_OFFSET = 5;
    localparam int unsigned IRQ_CLEAR_DMA_OFFSET = 6;

    // Status word bit positions
    localparam int unsigned IRQ_STATUS_VBLANK_BIT = 0;
    localparam int unsigned IRQ_STATUS_DMA_BIT = 1;

endpackage

// File: source/f2_region_config.sv
`timescale 1ns/1ps

module f2_region_config #(
    parameter f2_bus_pkg::page_t RESET_WORK_RAM_PAGE = 8'h10,
    parameter f2_bus_pkg::page_t RESET_IRQ_PAGE = 8'h30
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stb,
    input  logic                  we,
    input  f2_bus_pkg::bus_addr_t offset,
    input  f2_bus_pkg::bus_data_t wr_data,
    input  f2_bus_pkg::bus_sel_t  wr_sel,
    output f2_bus_pkg::bus_data_t rd_data,
    output f2_bus_pkg::page_t     work_ram_page,
    output f2_bus_pkg::page_t     irq_page
);

    import f2_bus_pkg::*;

    logic write_low;

    // Page bases live in the lower byte only
    assign write_low = stb & we & wr_sel[0];

    always_ff @(posedge clk) begin
        if (reset) begin
            work_ram_page <= RESET_WORK_RAM_PAGE;
            irq_page <= RESET_IRQ_PAGE;
        end else if (write_low) begin
            if (offset == CFG_WORK_RAM_OFFSET) begin
                work_ram_page <= wr_data[PAGE_W-1:0];
            end
            if (offset == CFG_IRQ_OFFSET) begin
                irq_page <= wr_data[PAGE_W-1:0];
            end
        end
    end

    // Read back, upper byte zero
    always_ff @(posedge clk) begin
        if (stb) begin
            case (offset)
                CFG_WORK_RAM_OFFSET: begin
                    rd_data <= {{(DATA_W - PAGE_W){1'b0}}, work_ram_page};
                end
                CFG_IRQ_OFFSET: begin
                    rd_data <= {{(DATA_W - PAGE_W){1'b0}}, irq_page};
                end
                default: begin
                    rd_data <= '0;
                end
            endcase
        end
    end

endmodule

// File: source/f2_system_ctrl.sv
`timescale 1ns/1ps

module f2_system_ctrl #(
    parameter f2_bus_pkg::page_t RESET_WORK_RAM_PAGE = 8'h10,
    parameter f2_bus_pkg::page_t RESET_IRQ_PAGE = 8'h30,
    parameter int WORK_RAM_ADDR_W = 12
) (
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  f2_bus_pkg::bus_addr_t  wb_adr,
    input  f2_bus_pkg::bus_data_t  wb_dat_w,
    input  f2_bus_pkg::bus_sel_t   wb_sel,
    output f2_bus_pkg::bus_data_t  wb_dat_r,
    output logic                   wb_ack,

    input  logic                   vblank,
    input  logic                   dma_done,
    output f2_irq_pkg::irq_level_t ipl
);

    import f2_bus_pkg::*;

    region_t region;
    page_t work_ram_page;
    page_t irq_page;

    bus_addr_t offset;
    bus_data_t wr_data;
    bus_sel_t wr_sel;
    logic wr_en;

    logic ram_stb;
    logic irq_stb;
    logic cfg_stb;
    bus_data_t ram_data;
    bus_data_t irq_data;
    bus_data_t cfg_data;

    ////////////////////////////////////////////////////////////////////////////
    // Bus front end and decode

    f2_cpu_bus i_f2_cpu_bus (
        .clk,
        .reset,
        .wb_cyc,
        .wb_stb,
        .wb_we,
        .wb_adr,
        .wb_dat_w,
        .wb_sel,
        .wb_dat_r,
        .wb_ack,
        .region,
        .offset,
        .wr_data,
        .wr_sel,
        .wr_en,
        .ram_stb,
        .irq_stb,
        .cfg_stb,
        .ram_data,
        .irq_data,
        .cfg_data
    );

    f2_chip_select i_f2_chip_select (
        .addr(wb_adr),
        .work_ram_page,
        .irq_page,
        .region
    );

    f2_region_config #(
        .RESET_WORK_RAM_PAGE(RESET_WORK_RAM_PAGE),
        .RESET_IRQ_PAGE(RESET_IRQ_PAGE)
    ) i_f2_region_config (
        .clk,
        .reset,
        .stb(cfg_stb),
        .we(wr_en),
        .offset,
        .wr_data,
        .wr_sel,
        .rd_data(cfg_data),
        .work_ram_page,
        .irq_page
    );

    ////////////////////////////////////////////////////////////////////////////
    // Targets

    f2_work_ram #(
        .WORK_RAM_ADDR_W(WORK_RAM_ADDR_W)
    ) i_f2_work_ram (
        .clk,
        .stb(ram_stb),
        .we(wr_en),
        .offset,
        .wr_data,
        .wr_sel,
        .rd_data(ram_data)
    );

    f2_irq_ctrl i_f2_irq_ctrl (
        .clk,
        .reset,
        .vblank,
        .dma_done,
        .stb(irq_stb),
        .we(wr_en),
        .offset,
        .rd_data(irq_data),
        .ipl
    );

endmodule

// File: source/f2_work_ram.sv
`timescale 1ns/1ps

module f2_work_ram #(
    parameter int WORK_RAM_ADDR_W = 12
) (
    input  logic                  clk,
    input  logic                  stb,
    input  logic                  we,
    input  f2_bus_pkg::bus_addr_t offset,
    input  f2_bus_pkg::bus_data_t wr_data,
    input  f2_bus_pkg::bus_sel_t  wr_sel,
    output f2_bus_pkg::bus_data_t rd_data
);

    import f2_bus_pkg::*;

    localparam int DEPTH = 1 << WORK_RAM_ADDR_W;

    bus_data_t mem [DEPTH];

    logic [WORK_RAM_ADDR_W-1:0] index;

    // Upper offset bits ignored, RAM mirrors through its page
    assign index = offset[WORK_RAM_ADDR_W-1:0];

    always_ff @(posedge clk) begin
        if (stb) begin
            if (we && wr_sel[1]) begin
                mem[index][15:8] <= wr_data[15:8];
            end
            if (we && wr_sel[0]) begin
                mem[index][7:0] <= wr_data[7:0];
            end
            // Old word on a write cycle
            rd_data <= mem[index];
        end
    end

endmodule

// File: testbench/f2_system_ctrl_checks.svh
`ifndef F2_SYSTEM_CTRL_CHECKS_SVH
`define F2_SYSTEM_CTRL_CHECKS_SVH

////////////////////////////////////////////////////////////////////////////
// Result compares

task automatic check_data(input bus_data_t actual, input bus_data_t expected,
                          input string what);
    if (actual !== expected) begin
        $display("Fail at %0t: %s returned %04h, expected %04h",
                 $time, what, actual, expected);
        abort_run();
    end
endtask

task automatic check_level(input irq_level_t actual, input irq_level_t expected,
                           input string what);
    if (actual !== expected) begin
        $display("Fail at %0t: %s is %s (%0d), expected %s (%0d)",
                 $time, what, actual.name(), actual, expected.name(), expected);
        abort_run();
    end
endtask

////////////////////////////////////////////////////////////////////////////
// Wishbone classic master

// One access, request held until ack, stb dropped right after
task automatic bus_access(input logic is_write, input bus_addr_t adr,
                          input bus_data_t data, input bus_sel_t sel,
                          output bus_data_t rd);
    int waited;
    waited = 0;
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we <= is_write;
    wb_adr <= adr;
    wb_dat_w <= data;
    wb_sel <= sel;
    do begin
        @(posedge clk);
        waited++;
    end while (wb_ack !== 1'b1 && waited < ACK_LIMIT);
    if (wb_ack !== 1'b1) begin
        $display("No ack from the DUT within %0d cycles for address %06h", ACK_LIMIT, adr);
        abort_run();
    end
    rd = wb_dat_r;
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we <= 1'b0;
    @(posedge clk);
    if (wb_ack !== 1'b0) begin
        $display("Ack stayed high for more than one cycle at address %06h", adr);
        abort_run();
    end
endtask

task automatic bus_write(input bus_addr_t adr, input bus_data_t data, input bus_sel_t sel);
    bus_data_t ignored;
    bus_access(1'b1, adr, data, sel, ignored);
endtask

task automatic bus_read(input bus_addr_t adr, input bus_sel_t sel, output bus_data_t rd);
    bus_access(1'b0, adr, '0, sel, rd);
endtask

`endif

// File: testbench/f2_system_ctrl_tb.sv
`timescale 1ns/1ps

module f2_system_ctrl_tb;

    import f2_bus_pkg::*;
    import f2_irq_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 4;
    localparam int ACK_LIMIT = 4;
    localparam int CYCLES_PER_OP = 20;
    localparam string TESTDATA_PATH = "testbench/f2_system_ctrl_testdata.txt";

    logic clk = 1'b0;
    logic reset;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    bus_addr_t wb_adr;
    bus_data_t wb_dat_w;
    bus_sel_t wb_sel;
    bus_data_t wb_dat_r;
    logic wb_ack;
    logic vblank;
    logic dma_done;
    irq_level_t ipl;

    integer seed = 32'h66aa;

    // Operation table, one entry per data line
    logic [7:0] op_code_q[$];
    bus_addr_t op_addr_q[$];
    bus_data_t op_data_q[$];
    bus_sel_t op_sel_q[$];
    bus_data_t op_expect_q[$];
    int num_ops = 0;
    logic ops_loaded = 1'b0;

    f2_system_ctrl #(
        .RESET_WORK_RAM_PAGE(8'h10),
        .RESET_IRQ_PAGE(8'h30),
        .WORK_RAM_ADDR_W(12)
    ) i_f2_system_ctrl (
        .clk,
        .reset,
        .wb_cyc,
        .wb_stb,
        .wb_we,
        .wb_adr,
        .wb_dat_w,
        .wb_sel,
        .wb_dat_r,
        .wb_ack,
        .vblank,
        .dma_done,
        .ipl
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    `include "f2_system_ctrl_checks.svh"

    task automatic load_testdata();
        int fd;
        int code;
        logic [7:0] op_char;
        logic [31:0] f_addr;
        logic [31:0] f_data;
        logic [31:0] f_sel;
        logic [31:0] f_expect;
        logic [8*256-1:0] rest_of_line;
        fd = $fopen(TESTDATA_PATH, "r");
        if (fd == 0) begin
            $display("Could not open the test data file %s", TESTDATA_PATH);
            abort_run();
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", op_char);
            if (code == 1) begin
                if (op_char == "#") begin
                    code = $fgets(rest_of_line, fd);
                end else begin
                    code = $fscanf(fd, "%h %h %h %h", f_addr, f_data, f_sel, f_expect);
                    if (code != 4) begin
                        $display("Malformed test data line for opcode %c", op_char);
                        abort_run();
                    end
                    op_code_q.push_back(op_char);
                    op_addr_q.push_back(f_addr[ADDR_W-1:0]);
                    op_data_q.push_back(f_data[DATA_W-1:0]);
                    op_sel_q.push_back(f_sel[SEL_W-1:0]);
                    op_expect_q.push_back(f_expect[DATA_W-1:0]);
                end
            end
        end
        $fclose(fd);
        num_ops = op_code_q.size();
    endtask

    // One cycle high pulse, edge lands in the IRQ block on the next edge
    task automatic pulse_irq_input(input logic is_dma);
        @(posedge clk);
        if (is_dma) begin
            dma_done <= 1'b1;
        end else begin
            vblank <= 1'b1;
        end
        @(posedge clk);
        dma_done <= 1'b0;
        vblank <= 1'b0;
    endtask

    task automatic idle_cycles();
        int n;
        n = $unsigned($random(seed)) % 4;
        repeat (n) @(posedge clk);
    endtask

    task automatic run_op(input int idx);
        bus_data_t rd;
        case (op_code_q[idx])
            "W": bus_write(op_addr_q[idx], op_data_q[idx], op_sel_q[idx]);
            "R": begin
                bus_read(op_addr_q[idx], op_sel_q[idx], rd);
                check_data(rd, op_expect_q[idx], $sformatf("read at %06h", op_addr_q[idx]));
            end
            "V": pulse_irq_input(1'b0);
            "D": pulse_irq_input(1'b1);
            "L": begin
                @(posedge clk);
                check_level(ipl, irq_level_t'(op_expect_q[idx][2:0]),
                            $sformatf("ipl at operation %0d", idx));
            end
            default: begin
                $display("Unknown opcode %c at operation %0d", op_code_q[idx], idx);
                abort_run();
            end
        endcase
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Watchdog

    initial begin
        int limit_ns;
        wait (ops_loaded);
        limit_ns = num_ops * CYCLES_PER_OP * CLK_PERIOD;
        #(limit_ns);
        $display("Test timed out after %0d ns with %0d operations", limit_ns, num_ops);
        abort_run();
    end

    initial begin
        $timeformat(-9, 0, " ns", 0);
        reset <= 1'b1;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
        wb_adr <= '0;
        wb_dat_w <= '0;
        wb_sel <= '0;
        vblank <= 1'b0;
        dma_done <= 1'b0;
        load_testdata();
        if (num_ops == 0) begin
            $display("The test data file holds no operations");
            abort_run();
        end
        ops_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_level(ipl, IRQ_NONE, "ipl after reset");
        if (wb_ack !== 1'b0) begin
            $display("Ack is high right after reset");
            abort_run();
        end
        for (int i = 0; i < num_ops; i++) begin
            idle_cycles();
            run_op(i);
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

// File: testbench/f2_system_ctrl_testdata.txt
# op addr data sel expect, all hex, addr is the 23-bit word address
# W write, R read and compare, V vblank pulse, D dma_done pulse, L compare ipl
# Work RAM at reset page 10, byte lanes and mirror
W 080000 1234 3 0000
R 080000 0000 3 1234
W 080001 abcd 3 0000
W 080000 ff55 1 0000
W 080001 66ee 2 0000
R 080000 0000 3 1255
R 080001 0000 3 66cd
R 081000 0000 3 1255
R 087001 0000 3 66cd
# Unmapped pages read zero
R 000000 0000 3 0000
W 2a0123 1111 3 0000
R 2a0123 0000 3 0000
# Configuration page, move work RAM to page 22
R 380000 0000 3 0010
R 380001 0000 3 0030
W 380000 0022 1 0000
R 380000 0000 3 0022
W 380001 0044 2 0000
R 380001 0000 3 0030
R 080000 0000 3 0000
R 110000 0000 3 1255
R 110001 0000 3 66cd
# Interrupts at page 30
L 000000 0000 0 0000
R 180000 0000 3 0000
V 000000 0000 0 0000
L 000000 0000 0 0005
R 180000 0000 3 0001
D 000000 0000 0 0000
L 000000 0000 0 0006
R 180000 0000 3 0003
R 180003 0000 3 0000
# Clear DMA then vblank
W 180006 0000 3 0000
L 000000 0000 0 0005
R 180000 0000 3 0001
W 180005 0000 3 0000
L 000000 0000 0 0000
R 180000 0000 3 0000
